// File: files.f
logic/lsu_pkg.sv
logic/lsu_range_check.sv
logic/lsu_addr_gen.sv
logic/lsu_addr_check.sv
logic/lsu_fault_encode.sv
logic/lsu_addr_path.sv
test/tb_lsu_addr_path.sv

// File: logic/lsu_addr_check.sv
// LSU memory-map check
// Decodes DCCM, PIC or external target for a dc1 access, raises
// access and misaligned faults, and pipes the side-effect attribute
// from the MRAC CSR into dc2 and dc3

`timescale 1ns/1ps

module lsu_addr_check
   import lsu_pkg::*;
#(
   parameter logic [31:0] DCCM_SADR    = 32'hf004_0000,
   parameter int          DCCM_SIZE_KB = 64,
   parameter logic [31:0] PIC_SADR     = 32'hf00c_0000,
   parameter int          PIC_SIZE_KB  = 32,
   parameter logic [3:0]  ICCM_REGION  = 4'he,
   parameter logic        DCCM_ENABLE  = 1'b1,
   parameter logic        ICCM_ENABLE  = 1'b1
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        freeze,           // Holds dc2 and dc3
   input  logic [31:0] start_addr,
   input  logic [31:0] end_addr,
   input  lsu_pkt_t    pkt,
   input  logic [31:0] mrac,             // CSR value
   output lsu_target_t target,
   output logic        access_fault,
   output logic        misaligned_fault,
   output logic        side_effects_dc2,
   output logic        side_effects_dc3
);

   localparam logic [3:0] DCCM_REGION = DCCM_SADR[31:28];
   localparam logic [3:0] PIC_REGION  = PIC_SADR[31:28];

   logic       start_in_dccm, end_in_dccm;
   logic       start_in_dccm_region, end_in_dccm_region;
   logic       start_in_pic, end_in_pic;
   logic       start_in_pic_region, end_in_pic_region;
   logic       addr_in_dccm, addr_in_pic, addr_external;
   logic       addr_in_iccm;
   logic       side_effects_dc1;
   logic       is_aligned;
   logic       req_checked;        // Valid core access, faults reported
   logic       access_fault_raw;
   logic [4:0] csr_idx;

   // **************************************************
   // Window checks
   // **************************************************
   if (DCCM_ENABLE) begin : g_dccm
      lsu_range_check #(.SADR(DCCM_SADR), .SIZE_KB(DCCM_SIZE_KB)) i_start_dccm (
         .addr      (start_addr),
         .in_range  (start_in_dccm),
         .in_region (start_in_dccm_region)
      );

      lsu_range_check #(.SADR(DCCM_SADR), .SIZE_KB(DCCM_SIZE_KB)) i_end_dccm (
         .addr      (end_addr),
         .in_range  (end_in_dccm),
         .in_region (end_in_dccm_region)
      );
   end else begin : g_no_dccm
      assign start_in_dccm        = 1'b0;
      assign start_in_dccm_region = 1'b0;
      assign end_in_dccm          = 1'b0;
      assign end_in_dccm_region   = 1'b0;
   end

   lsu_range_check #(.SADR(PIC_SADR), .SIZE_KB(PIC_SIZE_KB)) i_start_pic (
      .addr      (start_addr),
      .in_range  (start_in_pic),
      .in_region (start_in_pic_region)
   );

   lsu_range_check #(.SADR(PIC_SADR), .SIZE_KB(PIC_SIZE_KB)) i_end_pic (
      .addr      (end_addr),
      .in_range  (end_in_pic),
      .in_region (end_in_pic_region)
   );

   // Both ends must land in the same window
   assign addr_in_dccm  = start_in_dccm & end_in_dccm;
   assign addr_in_pic   = start_in_pic & end_in_pic;
   assign addr_external = ~(addr_in_dccm | addr_in_pic);

   always_comb begin
      target.in_dccm  = addr_in_dccm;
      target.in_pic   = addr_in_pic;
      target.external = addr_external;
   end

   // **************************************************
   // Side effects and alignment
   // **************************************************
   assign addr_in_iccm = ICCM_ENABLE & (start_addr[31:28] == ICCM_REGION);

   // Odd bit of each MRAC pair marks side effects
   assign csr_idx = {start_addr[31:28], 1'b1};

   // Internal memories never have side effects
   assign side_effects_dc1 = mrac[csr_idx] &
                             ~(start_in_dccm_region | start_in_pic_region | addr_in_iccm);

   assign is_aligned = (pkt.word & (start_addr[1:0] == 2'b00)) |
                       (pkt.half & ~start_addr[0]) |
                       pkt.by;

   assign req_checked = pkt.valid & ~pkt.dma;

   // **************************************************
   // Access fault
   // **************************************************
   if (DCCM_ENABLE && (DCCM_REGION == PIC_REGION)) begin : g_shared_region
      // One region holds both windows, a hole or a DCCM/PIC cross faults
      assign access_fault_raw =
         (start_in_dccm_region & ~(start_in_dccm | start_in_pic)) |
         (end_in_dccm_region & ~(end_in_dccm | end_in_pic)) |
         (start_in_dccm & end_in_pic) |
         (start_in_pic & end_in_dccm) |
         (addr_in_pic & ((start_addr[1:0] != 2'b00) | ~pkt.word));
   end else begin : g_split_region
      assign access_fault_raw =
         (start_in_dccm_region & ~start_in_dccm) |
         (end_in_dccm_region & ~end_in_dccm) |
         (start_in_pic_region & ~start_in_pic) |
         (end_in_pic_region & ~end_in_pic) |
         (addr_in_pic & ((start_addr[1:0] != 2'b00) | ~pkt.word));
   end

   assign access_fault = access_fault_raw & req_checked;

   // Region cross or unaligned side-effect access, external only
   assign misaligned_fault = ((start_addr[31:28] != end_addr[31:28]) |
                              (side_effects_dc1 & ~is_aligned)) &
                             addr_external & req_checked;

   // **************************************************
   // Side-effect pipe
   // **************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         side_effects_dc2 <= 1'b0;
         side_effects_dc3 <= 1'b0;
      end else if (!freeze) begin
         side_effects_dc2 <= side_effects_dc1;
         side_effects_dc3 <= side_effects_dc2;
      end
   end

endmodule

// File: logic/lsu_addr_gen.sv
// LSU address generation
// Adds the sign-extended 12-bit offset to the base register and
// derives the last byte address from the access size

`timescale 1ns/1ps

module lsu_addr_gen
   import lsu_pkg::*;
(
   input  lsu_pkt_t    pkt,
   input  logic [11:0] offset,
   input  logic [31:0] base,
   output logic [31:0] start_addr,
   output logic [31:0] end_addr
);

   logic [31:0] offset_ext;
   logic [1:0]  span;          // Bytes beyond the first one

   // Immediate is signed, as in the load/store encodings
   assign offset_ext = {{20{offset[11]}}, offset};

   assign start_addr = base + offset_ext;

   // **************************************************
   // Size span
   // **************************************************
   // byte 0, half 1, word 3
   always_comb begin
      span = 2'b00;
      if (pkt.word) begin
         span = 2'b11;
      end else if (pkt.half) begin
         span = 2'b01;
      end
   end

   assign end_addr = start_addr + {30'b0, span};   // Wraps at the top of memory

endmodule

// File: logic/lsu_addr_path.sv
// LSU address-check front end
// Address generation, memory-map check and exception record for a
// load/store access, dc1 through dc3

`timescale 1ns/1ps

module lsu_addr_path
   import lsu_pkg::*;
#(
   parameter logic [31:0] DCCM_SADR    = 32'hf004_0000,
   parameter int          DCCM_SIZE_KB = 64,
   parameter logic [31:0] PIC_SADR     = 32'hf00c_0000,
   parameter int          PIC_SIZE_KB  = 32,
   parameter logic [3:0]  ICCM_REGION  = 4'he,
   parameter logic        DCCM_ENABLE  = 1'b1,
   parameter logic        ICCM_ENABLE  = 1'b1
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        freeze,
   input  lsu_pkt_t    pkt_dc1,
   input  logic [31:0] base_dc1,
   input  logic [11:0] offset_dc1,
   input  logic [31:0] mrac,
   output logic [31:0] addr_dc1,
   output lsu_target_t target_dc1,
   output logic        access_fault_dc1,
   output logic        misaligned_fault_dc1,
   output lsu_exc_t    exc_dc2,
   output logic        side_effects_dc2,
   output logic        side_effects_dc3
);

   logic [31:0] end_addr_dc1;     // Last byte of the access

   // **************************************************
   // dc1 address
   // **************************************************
   lsu_addr_gen i_lsu_addr_gen (
      .pkt        (pkt_dc1),
      .offset     (offset_dc1),
      .base       (base_dc1),
      .start_addr (addr_dc1),
      .end_addr   (end_addr_dc1)
   );

   lsu_addr_check #(
      .DCCM_SADR    (DCCM_SADR),
      .DCCM_SIZE_KB (DCCM_SIZE_KB),
      .PIC_SADR     (PIC_SADR),
      .PIC_SIZE_KB  (PIC_SIZE_KB),
      .ICCM_REGION  (ICCM_REGION),
      .DCCM_ENABLE  (DCCM_ENABLE),
      .ICCM_ENABLE  (ICCM_ENABLE)
   ) i_lsu_addr_check (
      .clk              (clk),
      .arst_n           (arst_n),
      .freeze           (freeze),
      .start_addr       (addr_dc1),
      .end_addr         (end_addr_dc1),
      .pkt              (pkt_dc1),
      .mrac             (mrac),
      .target           (target_dc1),
      .access_fault     (access_fault_dc1),
      .misaligned_fault (misaligned_fault_dc1),
      .side_effects_dc2 (side_effects_dc2),
      .side_effects_dc3 (side_effects_dc3)
   );

   // **************************************************
   // dc2 exception record
   // **************************************************
   lsu_fault_encode i_lsu_fault_encode (
      .clk              (clk),
      .arst_n           (arst_n),
      .freeze           (freeze),
      .pkt              (pkt_dc1),
      .start_addr       (addr_dc1),
      .access_fault     (access_fault_dc1),
      .misaligned_fault (misaligned_fault_dc1),
      .exc_dc2          (exc_dc2)
   );

endmodule

// File: logic/lsu_fault_encode.sv
// LSU fault encoder
// Picks the RISC-V exception cause for a faulting dc1 access and
// registers it with the start address as the dc2 record

`timescale 1ns/1ps

module lsu_fault_encode
   import lsu_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        freeze,
   input  lsu_pkt_t    pkt,
   input  logic [31:0] start_addr,
   input  logic        access_fault,
   input  logic        misaligned_fault,
   output lsu_exc_t    exc_dc2
);

   lsu_exc_t   exc_dc1;
   logic [3:0] cause_dc1;

   // **************************************************
   // Cause select
   // **************************************************
   always_comb begin
      if (misaligned_fault) begin          // Misaligned wins over access
         cause_dc1 = pkt.store ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
      end else begin
         cause_dc1 = pkt.store ? EXC_STORE_ACCESS : EXC_LOAD_ACCESS;
      end
   end

   always_comb begin
      exc_dc1.valid = access_fault | misaligned_fault;
      exc_dc1.cause = cause_dc1;
      exc_dc1.mtval = start_addr;
   end

   // dc2 record, held while the pipe is frozen
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exc_dc2 <= '0;
      end else if (!freeze) begin
         exc_dc2 <= exc_dc1;
      end
   end

endmodule

// File: logic/lsu_pkg.sv
// LSU shared types
// Access packet, dc1 target flags, dc2 exception record and the
// RISC-V cause codes used by the address-check front end

package lsu_pkg;

   // **************************************************
   // Access request
   // **************************************************
   typedef struct packed {
      logic valid;
      logic by;         // Byte access
      logic half;       // Half-word access
      logic word;       // Word access
      logic load;
      logic store;
      logic unsign;     // Zero-extend load data
      logic dma;        // Request from DMA, no faults reported
   } lsu_pkt_t;

   // One-hot target of a dc1 access
   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
   } lsu_target_t;

   // **************************************************
   // Exception record, dc2
   // **************************************************
   typedef struct packed {
      logic        valid;
      logic [3:0]  cause;   // mcause exception code
      logic [31:0] mtval;   // Faulting start address
   } lsu_exc_t;

   // Exception codes from the privileged spec
   localparam logic [3:0] EXC_LOAD_MISALIGNED  = 4'd4;
   localparam logic [3:0] EXC_LOAD_ACCESS      = 4'd5;
   localparam logic [3:0] EXC_STORE_MISALIGNED = 4'd6;
   localparam logic [3:0] EXC_STORE_ACCESS     = 4'd7;

endpackage

// File: logic/lsu_range_check.sv
// Range check for a closely coupled memory
// Flags an address that falls in the 256 MB region of the memory
// and one that falls inside the memory window itself

`timescale 1ns/1ps

module lsu_range_check #(
   parameter logic [31:0] SADR    = 32'hf004_0000,
   parameter int          SIZE_KB = 64
) (
   input  logic [31:0] addr,
   output logic        in_range,
   output logic        in_region
);

   // Lowest address bit that is not an offset within the window
   localparam int TOP_BIT = 10 + $clog2(SIZE_KB);

   // Top nibble picks one of sixteen regions
   assign in_region = (addr[31:28] == SADR[31:28]);

   // Window is aligned to its size, so only the upper bits need to match
   assign in_range = (addr[31:TOP_BIT] == SADR[31:TOP_BIT]);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the LSU address-path testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_lsu_addr_path
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module "$TOP" \
   --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

// File: test/tb_lsu_addr_path.sv
// Testbench for the LSU address-check front end
// Directed tests and an LFSR sweep, checked against a model of the
// memory-map and fault rules

`timescale 1ns/1ps

module tb_lsu_addr_path
   import lsu_pkg::*;
();

   localparam logic [31:0] DCCM_LO  = 32'hf004_0000;
   localparam logic [31:0] DCCM_HI  = 32'hf005_0000;   // 64 KB window
   localparam logic [31:0] PIC_LO   = 32'hf00c_0000;
   localparam logic [31:0] PIC_HI   = 32'hf00c_8000;   // 32 KB window
   localparam logic [3:0]  ICCM_REG = 4'he;
   localparam lsu_pkt_t    IDLE     = '0;
   localparam int          SWEEP_LEN = 64;
   // About four times the cycles that all tests need
   localparam int          CYCLE_LIMIT = 4 * (SWEEP_LEN + 36);

   typedef struct packed {
      logic [31:0] addr;
      lsu_target_t target;
      logic        af;
      logic        mf;
      logic        se;
      lsu_exc_t    exc;
   } model_t;

   logic        clk = 1'b0;
   logic        arst_n;
   logic        freeze;
   lsu_pkt_t    pkt_dc1;
   logic [31:0] base_dc1;
   logic [11:0] offset_dc1;
   logic [31:0] mrac;
   logic [31:0] addr_dc1;
   lsu_target_t target_dc1;
   logic        access_fault_dc1;
   logic        misaligned_fault_dc1;
   lsu_exc_t    exc_dc2;
   logic        side_effects_dc2;
   logic        side_effects_dc3;

   int          checks = 0;
   int          errors = 0;
   int          tests = 0;
   int          cycles = 0;
   logic [31:0] lfsr = 32'hb4b0;
   logic [31:0] csr_val;                 // MRAC value for the next access
   lsu_exc_t    pend_exc, exp_exc;       // Record waiting for the edge, and in dc2
   logic        pend_se, exp_se2, exp_se3;
   logic        frz_prev;                // Freeze level at the last edge

   lsu_addr_path i_lsu_addr_path (.*);

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Verification failed");
         $finish;
      end
   end

   // **************************************************
   // Helpers
   // **************************************************
   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks = checks + 1;
      if (exp !== act) begin
         errors = errors + 1;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Cause and mtval only matter for a valid record
   task automatic check_exc(input lsu_exc_t exp);
      check("exc_dc2.valid", 64'(exp.valid), 64'(exc_dc2.valid));
      if (exp.valid) begin
         check("exc_dc2.cause", 64'(exp.cause), 64'(exc_dc2.cause));
         check("exc_dc2.mtval", 64'(exp.mtval), 64'(exc_dc2.mtval));
      end
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // size 0 byte, 1 half, 2 or 3 word
   function automatic lsu_pkt_t make_pkt(input logic [1:0] size, input logic st,
                                         input logic v, input logic d);
      lsu_pkt_t p;
      p = '0;
      p.valid = v;
      p.by = (size == 2'd0);
      p.half = (size == 2'd1);
      p.word = size[1];
      p.load = ~st;
      p.store = st;
      p.dma = d;
      return p;
   endfunction

   // **************************************************
   // Reference model
   // **************************************************
   function automatic model_t predict(input lsu_pkt_t p, input logic [31:0] base,
                                      input logic [11:0] off, input logic [31:0] csr);
      model_t      m;
      logic [31:0] s, e;
      logic        s_d, e_d, s_p, e_p, s_reg, e_reg, aligned, ok;
      logic [4:0]  idx;
      m = '0;
      s = base + {{20{off[11]}}, off};
      e = s + (p.word ? 32'd3 : (p.half ? 32'd1 : 32'd0));
      s_d = (s >= DCCM_LO) && (s < DCCM_HI);
      e_d = (e >= DCCM_LO) && (e < DCCM_HI);
      s_p = (s >= PIC_LO) && (s < PIC_HI);
      e_p = (e >= PIC_LO) && (e < PIC_HI);
      s_reg = (s[31:28] == DCCM_LO[31:28]);      // DCCM and PIC share region f
      e_reg = (e[31:28] == DCCM_LO[31:28]);
      m.addr = s;
      m.target.in_dccm = s_d & e_d;
      m.target.in_pic = s_p & e_p;
      m.target.external = ~(m.target.in_dccm | m.target.in_pic);
      ok = p.valid & ~p.dma;
      m.af = ok & ((s_reg & ~s_d & ~s_p) | (e_reg & ~e_d & ~e_p) | (s_d & e_p) | (s_p & e_d) |
                   (m.target.in_pic & (~p.word | (s[1:0] != 2'b00))));
      idx = 5'(2 * int'(s[31:28]) + 1);
      m.se = csr[idx] & ~s_reg & (s[31:28] != ICCM_REG);
      aligned = p.by | (p.half & ~s[0]) | (p.word & (s[1:0] == 2'b00));
      m.mf = ok & m.target.external & ((s[31:28] != e[31:28]) | (m.se & ~aligned));
      m.exc.valid = m.af | m.mf;
      if (m.mf) begin
         m.exc.cause = p.store ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
      end else begin
         m.exc.cause = p.store ? EXC_STORE_ACCESS : EXC_LOAD_ACCESS;
      end
      m.exc.mtval = s;
      return m;
   endfunction

   // One cycle: check dc2/dc3 from the last edge, drive, check dc1
   task automatic step(input lsu_pkt_t p, input logic [31:0] base, input logic [11:0] off,
                       input logic frz);
      model_t m;
      @(posedge clk);
      #0.5;
      if (!frz_prev) begin
         exp_se3 = exp_se2;
         exp_se2 = pend_se;
         exp_exc = pend_exc;
      end
      check_exc(exp_exc);
      check("side_effects_dc2", 64'(exp_se2), 64'(side_effects_dc2));
      check("side_effects_dc3", 64'(exp_se3), 64'(side_effects_dc3));
      pkt_dc1 = p;
      base_dc1 = base;
      offset_dc1 = off;
      mrac = csr_val;
      freeze = frz;
      #1.5;
      m = predict(p, base, off, csr_val);
      check("addr_dc1", 64'(m.addr), 64'(addr_dc1));
      check("target_dc1", 64'(m.target), 64'(target_dc1));
      check("access_fault_dc1", 64'(m.af), 64'(access_fault_dc1));
      check("misaligned_fault_dc1", 64'(m.mf), 64'(misaligned_fault_dc1));
      pend_exc = m.exc;
      pend_se = m.se;
      frz_prev = frz;
   endtask

   task automatic finish_test(input string name, input int err0);
      tests = tests + 1;
      if (errors == err0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d error(s)", name, errors - err0);
      end
   endtask

   // **************************************************
   // Tests
   // **************************************************
   task automatic test_hits();
      int err0;
      err0 = errors;
      csr_val = '0;
      step(make_pkt(2'd2, 1'b0, 1'b1, 1'b0), 32'hf004_1000, 12'hffc, 1'b0); // Negative offset
      check("target_dc1", 64'(3'b100), 64'(target_dc1));
      step(make_pkt(2'd2, 1'b0, 1'b1, 1'b0), 32'hf004_fff0, 12'h00c, 1'b0); // Last DCCM word
      check("target_dc1", 64'(3'b100), 64'(target_dc1));
      step(make_pkt(2'd2, 1'b1, 1'b1, 1'b0), 32'hf00c_0100, 12'h000, 1'b0);
      check("target_dc1", 64'(3'b010), 64'(target_dc1));
      step(IDLE, '0, '0, 1'b0);
      check("exc_dc2.valid", 64'(0), 64'(exc_dc2.valid));
      finish_test("dccm_pic_hits", err0);
   endtask

   task automatic test_access_faults();
      int err0;
      err0 = errors;
      step(make_pkt(2'd2, 1'b0, 1'b1, 1'b0), 32'hf006_0000, 12'h000, 1'b0); // Region hole
      check("access_fault_dc1", 64'(1), 64'(access_fault_dc1));
      step(make_pkt(2'd2, 1'b1, 1'b1, 1'b0), 32'hf004_fffe, 12'h000, 1'b0); // Past DCCM end
      check("access_fault_dc1", 64'(1), 64'(access_fault_dc1));
      check("exc_dc2.cause", 64'(EXC_LOAD_ACCESS), 64'(exc_dc2.cause));
      step(make_pkt(2'd1, 1'b0, 1'b1, 1'b0), 32'hf00c_0010, 12'h000, 1'b0); // Half to PIC
      check("access_fault_dc1", 64'(1), 64'(access_fault_dc1));
      check("exc_dc2.cause", 64'(EXC_STORE_ACCESS), 64'(exc_dc2.cause));
      step(IDLE, '0, '0, 1'b0);
      check("exc_dc2.mtval", 64'(32'hf00c_0010), 64'(exc_dc2.mtval));
      finish_test("access_faults", err0);
   endtask

   task automatic test_misaligned();
      int err0;
      err0 = errors;
      csr_val = 32'h0002_0000;            // Side effects in region 8 only
      step(make_pkt(2'd2, 1'b1, 1'b1, 1'b0), 32'h7fff_fffe, 12'h000, 1'b0);
      check("misaligned_fault_dc1", 64'(1), 64'(misaligned_fault_dc1));
      step(make_pkt(2'd1, 1'b0, 1'b1, 1'b0), 32'h8000_0001, 12'h000, 1'b0);
      check("misaligned_fault_dc1", 64'(1), 64'(misaligned_fault_dc1));
      check("exc_dc2.cause", 64'(EXC_STORE_MISALIGNED), 64'(exc_dc2.cause));
      step(make_pkt(2'd1, 1'b0, 1'b1, 1'b0), 32'h9000_0001, 12'h000, 1'b0);
      check("misaligned_fault_dc1", 64'(0), 64'(misaligned_fault_dc1));
      check("exc_dc2.cause", 64'(EXC_LOAD_MISALIGNED), 64'(exc_dc2.cause));
      check("side_effects_dc2", 64'(1), 64'(side_effects_dc2));
      step(IDLE, '0, '0, 1'b0);
      check("side_effects_dc3", 64'(1), 64'(side_effects_dc3));
      finish_test("misaligned_side_effects", err0);
   endtask

   task automatic test_suppress();
      int err0;
      err0 = errors;
      csr_val = '0;
      step(make_pkt(2'd2, 1'b0, 1'b1, 1'b1), 32'hf006_0000, 12'h000, 1'b0); // DMA
      check("access_fault_dc1", 64'(0), 64'(access_fault_dc1));
      check("target_dc1", 64'(3'b001), 64'(target_dc1));
      step(make_pkt(2'd1, 1'b0, 1'b0, 1'b0), 32'hf00c_0010, 12'h000, 1'b0); // Not valid
      check("access_fault_dc1", 64'(0), 64'(access_fault_dc1));
      check("target_dc1", 64'(3'b010), 64'(target_dc1));
      step(IDLE, '0, '0, 1'b0);
      check("exc_dc2.valid", 64'(0), 64'(exc_dc2.valid));
      finish_test("suppression", err0);
   endtask

   task automatic test_freeze();
      int       err0;
      lsu_exc_t held;
      err0 = errors;
      csr_val = 32'h0002_8000;            // Side effects in regions 7 and 8
      step(make_pkt(2'd1, 1'b0, 1'b1, 1'b0), 32'h8000_0001, 12'h000, 1'b0);
      step(make_pkt(2'd2, 1'b0, 1'b1, 1'b0), 32'hf006_0000, 12'h000, 1'b0);
      step(make_pkt(2'd2, 1'b0, 1'b1, 1'b0), 32'hf004_0000, 12'h000, 1'b1);
      held.valid = 1'b1;                  // Hole load from the second access
      held.cause = EXC_LOAD_ACCESS;
      held.mtval = 32'hf006_0000;
      step(make_pkt(2'd2, 1'b1, 1'b1, 1'b0), 32'h7fff_fffe, 12'h000, 1'b1);
      check("exc_dc2", 64'(held), 64'(exc_dc2));
      check("side_effects_dc3", 64'(1), 64'(side_effects_dc3));
      step(make_pkt(2'd2, 1'b0, 1'b1, 1'b0), 32'h9000_0000, 12'h000, 1'b0);
      check("exc_dc2", 64'(held), 64'(exc_dc2));
      step(IDLE, '0, '0, 1'b0);            // Pipe moves again
      check("exc_dc2.valid", 64'(0), 64'(exc_dc2.valid));
      check("side_effects_dc3", 64'(0), 64'(side_effects_dc3));
      finish_test("freeze", err0);
   endtask

   task automatic test_sweep();
      int          err0;
      logic [31:0] r, base;
      logic [11:0] off;
      logic [1:0]  area;
      err0 = errors;
      rand_bits(32, csr_val);
      for (int i = 0; i < SWEEP_LEN; i++) begin
         rand_bits(2, r);
         area = r[1:0];
         rand_bits(12, r);
         off = r[11:0];
         case (area)
            2'd0: begin
               rand_bits(17, r);
               base = DCCM_LO + r;          // Around the DCCM window
            end
            2'd1: begin
               rand_bits(16, r);
               base = PIC_LO + r;
            end
            2'd2: begin
               rand_bits(4, r);
               base = {r[3:0], 28'hffffff8}; // Just below a region boundary
               off = {9'b0, off[2:0]};
            end
            default: rand_bits(32, base);
         endcase
         rand_bits(2, r);
         area = r[1:0];                     // Reused as the size
         rand_bits(1, r);
         step(make_pkt(area, r[0], 1'b1, 1'b0), base, off, 1'b0);
      end
      step(IDLE, '0, '0, 1'b0);
      finish_test("random_sweep", err0);
   endtask

   // **************************************************
   // Main sequence
   // **************************************************
   initial begin
      arst_n = 1'b0;
      freeze = 1'b0;
      pkt_dc1 = '0;
      base_dc1 = '0;
      offset_dc1 = '0;
      mrac = '0;
      csr_val = '0;
      pend_exc = '0;
      exp_exc = '0;
      pend_se = 1'b0;
      exp_se2 = 1'b0;
      exp_se3 = 1'b0;
      frz_prev = 1'b0;
      repeat (2) @(posedge clk);
      #0.5;
      check("exc_dc2", 64'(0), 64'(exc_dc2));
      check("side_effects_dc2", 64'(0), 64'(side_effects_dc2));
      check("side_effects_dc3", 64'(0), 64'(side_effects_dc3));
      arst_n = 1'b1;
      test_hits();
      test_access_faults();
      test_misaligned();
      test_suppress();
      test_freeze();
      test_sweep();
      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
